// ==== boot_mem_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// boot memory shared definitions
// ram geometry, rom signature bytes and
// the fill value used by the eraser
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package boot_mem_pkg;

	// byte lane of the system ram
	localparam int DATA_WIDTH = 8;

	typedef logic [DATA_WIDTH-1:0] byte_t;

	// default geometry, 64k of ram
	localparam int ADDR_WIDTH_DEF = 16;

	// cpu runs at sys_clock / 8
	localparam int ENA_DIV_DEF = 8;

	// program area starts halfway up, rom lives below it
	localparam logic [15:0] PRG_BASE = 16'h8000;

	localparam byte_t FILL_BYTE = 8'h00; // value left behind by the eraser

	// first bytes of a valid firmware image
	localparam int SIG_LEN = 4;

	localparam byte_t ROM_SIG [0:SIG_LEN-1] = '{
		8'hF3, // di
		8'hC3, // jp ...
		8'h5A, // ... lo
		8'h02  // ... hi
	};

endpackage

// ==== boot_control.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu boot control
// clock enable divider plus the cpu
// reset and wait terms
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module boot_control #(
	parameter int ENA_DIV = boot_mem_pkg::ENA_DIV_DEF
) (
	input  logic sys_clock,
	input  logic RESET,
	input  logic load_done,   // rom image present
	input  logic load_active, // loader owns the ram
	input  logic reset_key,
	input  logic erase_busy,
	input  logic check_done,
	output logic cpu_ena,
	output logic cpu_reset,
	output logic cpu_wait
);

	// one bit minimum so ENA_DIV of 1 still elaborates
	localparam int CNT_W = (ENA_DIV > 1) ? $clog2(ENA_DIV) : 1;

	logic [CNT_W-1:0] ena_cnt;

	// free running divider, wraps at ENA_DIV-1
	always_ff @(posedge sys_clock) begin
		if (RESET) begin
			ena_cnt <= '0; // zero right after reset, first enable immediate
		end else if (ena_cnt == CNT_W'(ENA_DIV - 1)) begin
			ena_cnt <= '0;
		end else begin
			ena_cnt <= ena_cnt + 1'b1;
		end
	end

	assign cpu_ena = (ena_cnt == '0); // one cycle in ENA_DIV

	// cpu held in reset while booting, on the reset key or while erasing
	assign cpu_reset = RESET | ~load_done | reset_key | erase_busy;

	// stall while rom missing, download running or signature not yet checked
	assign cpu_wait = ~load_done | load_active | ~check_done;

endmodule

// ==== ram_eraser.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program area eraser
// on a trigger strobe sweeps PRG_BASE up
// to the top address writing the fill
// byte, one write per cpu enable
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ram_eraser #(
	parameter int ADDR_WIDTH = boot_mem_pkg::ADDR_WIDTH_DEF
) (
	input  logic                    sys_clock,
	input  logic                    RESET,
	input  logic                    cpu_ena,
	input  logic                    erase_trigger, // single cycle strobe
	output logic                    erase_busy,
	output logic                    erase_wr,
	output logic [ADDR_WIDTH-1:0]   erase_addr,
	output boot_mem_pkg::byte_t     erase_data
);

	import boot_mem_pkg::*;

	typedef enum logic {
		ERASE_IDLE,
		ERASE_BUSY
	} erase_state_t;

	localparam logic [ADDR_WIDTH-1:0] START_ADDR = ADDR_WIDTH'(PRG_BASE);
	localparam logic [ADDR_WIDTH-1:0] TOP_ADDR   = '1; // last ram byte

	erase_state_t          state;
	logic [ADDR_WIDTH-1:0] addr_cnt;

	always_ff @(posedge sys_clock) begin
		if (RESET) begin
			state    <= ERASE_IDLE;
			addr_cnt <= START_ADDR;
		end else begin
			case (state)
				ERASE_IDLE: begin
					if (erase_trigger) begin // strobes while busy are dropped
						state    <= ERASE_BUSY;
						addr_cnt <= START_ADDR;
					end
				end
				ERASE_BUSY: begin
					if (cpu_ena) begin
						if (addr_cnt == TOP_ADDR)
							state <= ERASE_IDLE; // top byte written this edge
						else
							addr_cnt <= addr_cnt + 1'b1;
					end
				end
				default: state <= ERASE_IDLE;
			endcase
		end
	end

	assign erase_busy = (state == ERASE_BUSY);
	assign erase_wr   = erase_busy & cpu_ena; // paced like the cpu
	assign erase_addr = addr_cnt;
	assign erase_data = FILL_BYTE;

endmodule

// ==== rom_check.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rom signature checker
// after boot reads the first SIG_LEN ram
// bytes and raises rom_ok when they all
// match the expected firmware signature
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module rom_check #(
	parameter int ADDR_WIDTH = boot_mem_pkg::ADDR_WIDTH_DEF
) (
	input  logic                  sys_clock,
	input  logic                  cpu_reset,  // whole checker restarts on cpu reset
	input  logic                  cpu_ena,
	input  logic                  load_done,
	input  boot_mem_pkg::byte_t   ram_q,
	output logic                  check_busy,
	output logic [ADDR_WIDTH-1:0] check_addr,
	output logic                  check_done,
	output logic                  rom_ok
);

	import boot_mem_pkg::*;

	// steps 0..SIG_LEN, step k compares the byte fetched at step k-1
	localparam int STEP_W = $clog2(SIG_LEN + 1);
	localparam int IDX_W  = (SIG_LEN > 1) ? $clog2(SIG_LEN) : 1;

	logic [STEP_W-1:0] step;
	logic [STEP_W-1:0] match_cnt;
	logic [IDX_W-1:0]  sig_idx;
	logic              sig_hit;
	logic              last_step;

	assign sig_idx   = IDX_W'(step - 1'b1);
	assign sig_hit   = (step != '0) && (ram_q == ROM_SIG[sig_idx]); // nothing fetched at step 0
	assign last_step = (step == STEP_W'(SIG_LEN));

	always_ff @(posedge sys_clock) begin
		if (cpu_reset) begin
			check_busy <= 1'b0;
			check_done <= 1'b0;
			rom_ok     <= 1'b0;
			step       <= '0;
			match_cnt  <= '0;
			check_addr <= '0;
		end else if (load_done && !check_done) begin
			check_busy <= 1'b1; // grab the bus right away

			if (cpu_ena) begin
				// ram_q holds the byte addressed one enable ago
				if (sig_hit)
					match_cnt <= match_cnt + 1'b1;

				if (last_step) begin
					check_busy <= 1'b0;
					check_done <= 1'b1;
					// last compare still pending in match_cnt
					rom_ok     <= sig_hit && (match_cnt == STEP_W'(SIG_LEN - 1));
				end else begin
					check_addr <= ADDR_WIDTH'(step); // next signature byte
					step       <= step + 1'b1;
				end
			end
		end
	end

	// flags hold until the next cpu reset

endmodule

// ==== mem_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// system ram bus owner decode
// fixed priority, loader then eraser then
// checker then cpu
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mem_arbiter #(
	parameter int ADDR_WIDTH = boot_mem_pkg::ADDR_WIDTH_DEF
) (
	input  logic                  load_active,
	input  logic                  load_wr,
	input  logic [ADDR_WIDTH-1:0] load_addr,
	input  boot_mem_pkg::byte_t   load_data,
	input  logic                  erase_busy,
	input  logic                  erase_wr,
	input  logic [ADDR_WIDTH-1:0] erase_addr,
	input  boot_mem_pkg::byte_t   erase_data,
	input  logic                  check_busy,
	input  logic [ADDR_WIDTH-1:0] check_addr,
	input  logic [ADDR_WIDTH-1:0] cpu_addr,
	input  boot_mem_pkg::byte_t   cpu_wdata,
	input  logic                  cpu_wr,
	output logic [ADDR_WIDTH-1:0] ram_addr,
	output boot_mem_pkg::byte_t   ram_wdata,
	output logic                  ram_we
);

	always_comb begin
		if (load_active && load_wr) begin
			// loader only wins on its write strobes
			ram_addr  = load_addr;
			ram_wdata = load_data;
			ram_we    = 1'b1;
		end else if (erase_busy) begin
			ram_addr  = erase_addr;
			ram_wdata = erase_data;
			ram_we    = erase_wr; // writes only on enable cycles
		end else if (check_busy) begin
			ram_addr  = check_addr;
			ram_wdata = cpu_wdata; // don't care, read only
			ram_we    = 1'b0;
		end else begin
			ram_addr  = cpu_addr;
			ram_wdata = cpu_wdata;
			ram_we    = cpu_wr;
		end
	end

	// cpu write while another owner holds the bus is simply lost

endmodule

// ==== sys_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// system ram
// single port, synchronous write and a
// registered read one cycle behind
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sys_ram #(
	parameter int ADDR_WIDTH = boot_mem_pkg::ADDR_WIDTH_DEF
) (
	input  logic                  sys_clock,
	input  logic [ADDR_WIDTH-1:0] ram_addr,
	input  boot_mem_pkg::byte_t   ram_wdata,
	input  logic                  ram_we,
	output boot_mem_pkg::byte_t   ram_q
);

	import boot_mem_pkg::*;

	localparam int DEPTH = 2 ** ADDR_WIDTH;

	byte_t mem [0:DEPTH-1]; // infers block ram

	always_ff @(posedge sys_clock) begin
		if (ram_we)
			mem[ram_addr] <= ram_wdata;
		ram_q <= mem[ram_addr]; // old data on a write cycle
	end

endmodule

// ==== boot_mem_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// boot memory subsystem top level
// cpu timing, eraser, signature checker,
// ram arbiter and the system ram
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module boot_mem_top #(
	parameter int ADDR_WIDTH = boot_mem_pkg::ADDR_WIDTH_DEF,
	parameter int ENA_DIV    = boot_mem_pkg::ENA_DIV_DEF
) (
	input  logic                  sys_clock,
	input  logic                  RESET,
	// external loader
	input  logic                  load_active,
	input  logic                  load_wr,
	input  logic [ADDR_WIDTH-1:0] load_addr,
	input  boot_mem_pkg::byte_t   load_data,
	input  logic                  load_done,
	// user controls
	input  logic                  erase_trigger,
	input  logic                  reset_key,
	// cpu side
	input  logic [ADDR_WIDTH-1:0] cpu_addr,
	input  boot_mem_pkg::byte_t   cpu_wdata,
	input  logic                  cpu_wr,
	output logic                  cpu_reset,
	output logic                  cpu_wait,
	output logic                  cpu_ena,
	output logic                  rom_ok,
	output boot_mem_pkg::byte_t   ram_q
);

	import boot_mem_pkg::*;

	logic                  erase_busy;
	logic                  erase_wr;
	logic [ADDR_WIDTH-1:0] erase_addr;
	byte_t                 erase_data;

	logic                  check_busy;
	logic                  check_done;
	logic [ADDR_WIDTH-1:0] check_addr;

	logic [ADDR_WIDTH-1:0] ram_addr;  // arbitrated bus
	byte_t                 ram_wdata;
	logic                  ram_we;

	boot_control #(.ENA_DIV(ENA_DIV)) boot_control_inst (
		.sys_clock   (sys_clock),
		.RESET       (RESET),
		.load_done   (load_done),
		.load_active (load_active),
		.reset_key   (reset_key),
		.erase_busy  (erase_busy),
		.check_done  (check_done),
		.cpu_ena     (cpu_ena),
		.cpu_reset   (cpu_reset),
		.cpu_wait    (cpu_wait)
	);

	ram_eraser #(.ADDR_WIDTH(ADDR_WIDTH)) ram_eraser_inst (
		.sys_clock     (sys_clock),
		.RESET         (RESET),
		.cpu_ena       (cpu_ena),       // sweep paced by the cpu enable
		.erase_trigger (erase_trigger),
		.erase_busy    (erase_busy),
		.erase_wr      (erase_wr),
		.erase_addr    (erase_addr),
		.erase_data    (erase_data)
	);

	// restarts after every cpu reset, so an erase re-checks the rom
	rom_check #(.ADDR_WIDTH(ADDR_WIDTH)) rom_check_inst (
		.sys_clock  (sys_clock),
		.cpu_reset  (cpu_reset),
		.cpu_ena    (cpu_ena),
		.load_done  (load_done),
		.ram_q      (ram_q),
		.check_busy (check_busy),
		.check_addr (check_addr),
		.check_done (check_done),
		.rom_ok     (rom_ok)
	);

	mem_arbiter #(.ADDR_WIDTH(ADDR_WIDTH)) mem_arbiter_inst (
		.load_active (load_active),
		.load_wr     (load_wr),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.erase_busy  (erase_busy),
		.erase_wr    (erase_wr),
		.erase_addr  (erase_addr),
		.erase_data  (erase_data),
		.check_busy  (check_busy),
		.check_addr  (check_addr),
		.cpu_addr    (cpu_addr),
		.cpu_wdata   (cpu_wdata),
		.cpu_wr      (cpu_wr),
		.ram_addr    (ram_addr),
		.ram_wdata   (ram_wdata),
		.ram_we      (ram_we)
	);

	sys_ram #(.ADDR_WIDTH(ADDR_WIDTH)) sys_ram_inst (
		.sys_clock (sys_clock),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_we    (ram_we),
		.ram_q     (ram_q)  // shared by cpu and checker
	);

endmodule

// ==== boot_mem_assertions.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// boot memory assertions
// bound onto the top level, watch the
// cpu enable, reset term and bus owner
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module boot_mem_assertions #(
	parameter int ENA_DIV = boot_mem_pkg::ENA_DIV_DEF
) (
	input logic sys_clock,
	input logic RESET,
	input logic cpu_ena,
	input logic cpu_reset,
	input logic load_active,
	input logic load_wr,
	input logic erase_busy,
	input logic check_busy,
	input logic ram_we
);

	logic check_owns_bus;

	// checker only owns the bus when loader and eraser are quiet
	assign check_owns_bus = check_busy & ~(load_active & load_wr) & ~erase_busy;

	generate
		if (ENA_DIV > 1) begin : g_ena_gap
			ena_gap: assert property (@(posedge sys_clock) disable iff (RESET)
				(!RESET && cpu_ena) |=> !cpu_ena)
				else $error("cpu_ena high in two consecutive cycles");
		end
	endgenerate

	reset_follows: assert property (@(posedge sys_clock) RESET |-> cpu_reset)
		else $error("cpu_reset low while RESET is high");

	check_read_only: assert property (@(posedge sys_clock) disable iff (RESET)
		check_owns_bus |-> !ram_we)
		else $error("ram write while the signature checker owns the bus");

endmodule

bind boot_mem_top boot_mem_assertions #(.ENA_DIV(ENA_DIV)) boot_mem_assertions_inst (
	.sys_clock   (sys_clock),
	.RESET       (RESET),
	.cpu_ena     (cpu_ena),
	.cpu_reset   (cpu_reset),
	.load_active (load_active),
	.load_wr     (load_wr),
	.erase_busy  (erase_busy),
	.check_busy  (check_busy),
	.ram_we      (ram_we)
);

// ==== tb_boot_mem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// boot memory testbench
// directed tests for reset hold, rom
// signature check, cpu ram access and
// the program area eraser
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_boot_mem;

	import boot_mem_pkg::*;

	localparam int ADDR_WIDTH      = ADDR_WIDTH_DEF;
	localparam int ENA_DIV         = ENA_DIV_DEF;
	localparam int PRG_SIZE        = (1 << ADDR_WIDTH) - int'(PRG_BASE); // bytes per erase
	localparam int BOOT_LIMIT      = 4 * (SIG_LEN + 2) * ENA_DIV;        // rom check bound
	localparam int ERASE_LIMIT     = PRG_SIZE * ENA_DIV + 100;
	localparam int WATCHDOG_CYCLES = 2 * (PRG_SIZE * ENA_DIV + 2000);
	localparam int N_ACCESS        = 8;

	logic                  sys_clock;
	logic                  RESET;
	logic                  load_active;
	logic                  load_wr;
	logic [ADDR_WIDTH-1:0] load_addr;
	byte_t                 load_data;
	logic                  load_done;
	logic                  erase_trigger;
	logic                  reset_key;
	logic [ADDR_WIDTH-1:0] cpu_addr;
	byte_t                 cpu_wdata;
	logic                  cpu_wr;
	logic                  cpu_reset;
	logic                  cpu_wait;
	logic                  cpu_ena;
	logic                  rom_ok;
	byte_t                 ram_q;

	integer seed;
	int     errors;
	int     checks;

	boot_mem_top #(.ADDR_WIDTH(ADDR_WIDTH), .ENA_DIV(ENA_DIV)) boot_mem_top_inst (
		.sys_clock     (sys_clock),
		.RESET         (RESET),
		.load_active   (load_active),
		.load_wr       (load_wr),
		.load_addr     (load_addr),
		.load_data     (load_data),
		.load_done     (load_done),
		.erase_trigger (erase_trigger),
		.reset_key     (reset_key),
		.cpu_addr      (cpu_addr),
		.cpu_wdata     (cpu_wdata),
		.cpu_wr        (cpu_wr),
		.cpu_reset     (cpu_reset),
		.cpu_wait      (cpu_wait),
		.cpu_ena       (cpu_ena),
		.rom_ok        (rom_ok),
		.ram_q         (ram_q)
	);

	initial begin
		sys_clock = 1'b0;
		forever #2 sys_clock = ~sys_clock; // 4 ns period
	end

	// erase sweep dominates the run time
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clock);
		$display("watchdog expired, tests still running after %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("ERR %s expected %0h got %0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic apply_reset();
		@(negedge sys_clock);
		RESET         = 1'b1;
		load_done     = 1'b0; // rom gone again
		load_active   = 1'b0;
		load_wr       = 1'b0;
		erase_trigger = 1'b0;
		reset_key     = 1'b0;
		cpu_wr        = 1'b0;
		repeat (4) @(negedge sys_clock);
		RESET = 1'b0;
	endtask

	// bad_idx < 0 loads a clean signature
	task automatic load_image(input int bad_idx);
		byte_t b;
		int    k;
		apply_reset();
		@(negedge sys_clock);
		load_active = 1'b1;
		for (k = 0; k < SIG_LEN; k++) begin
			b = ROM_SIG[k];
			if (k == bad_idx)
				b = ~b; // corrupt one byte
			@(negedge sys_clock);
			load_addr = ADDR_WIDTH'(k);
			load_data = b;
			load_wr   = 1'b1; // single cycle strobe
			@(negedge sys_clock);
			load_wr   = 1'b0;
		end
		@(negedge sys_clock);
		load_done   = 1'b1;
		load_active = 1'b0;
	endtask

	task automatic wait_cpu_run();
		int n;
		n = 0;
		do begin
			@(negedge sys_clock);
			n++;
		end while (cpu_wait && n < BOOT_LIMIT);
		if (cpu_wait) begin
			$display("cpu_wait still high after %0d cycles, rom check never finished", n);
			errors++;
		end
	endtask

	task automatic cpu_write(input logic [ADDR_WIDTH-1:0] addr, input byte_t data);
		@(negedge sys_clock);
		cpu_addr  = addr;
		cpu_wdata = data;
		cpu_wr    = 1'b1;
		@(negedge sys_clock);
		cpu_wr    = 1'b0;
	endtask

	task automatic cpu_read(input logic [ADDR_WIDTH-1:0] addr, output byte_t data);
		@(negedge sys_clock);
		cpu_addr = addr;
		cpu_wr   = 1'b0;
		@(negedge sys_clock);
		data = ram_q; // registered read lands one cycle later
	endtask

	task automatic reset_hold();
		int pulses;
		apply_reset();
		@(negedge sys_clock);
		compare("cpu_reset", 1, 32'(cpu_reset));
		compare("cpu_wait", 1, 32'(cpu_wait));
		compare("rom_ok", 0, 32'(rom_ok));
		pulses = 0;
		repeat (4 * ENA_DIV) begin
			if (cpu_ena)
				pulses++;
			@(negedge sys_clock);
		end
		compare("cpu_ena pulses", 4, pulses);
	endtask

	task automatic good_rom_boot();
		byte_t rdata;
		load_image(-1);
		cpu_write('0, ~ROM_SIG[0]); // lost while the checker owns the bus
		wait_cpu_run();
		compare("rom_ok", 1, 32'(rom_ok));
		compare("cpu_reset", 0, 32'(cpu_reset));
		cpu_read('0, rdata);
		compare("ram_q@0000", 32'(ROM_SIG[0]), 32'(rdata));
	endtask

	task automatic bad_rom_boot();
		load_image(2); // jump target byte wrong
		wait_cpu_run();
		compare("rom_ok", 0, 32'(rom_ok));
	endtask

	task automatic random_ram_access();
		logic [ADDR_WIDTH-1:0] addr;
		byte_t                 wdata;
		byte_t                 rdata;
		repeat (N_ACCESS) begin
			addr = ADDR_WIDTH'($random(seed));
			if (addr < ADDR_WIDTH'(SIG_LEN))
				addr = ADDR_WIDTH'(SIG_LEN); // keep the signature intact
			wdata = byte_t'($random(seed));
			cpu_write(addr, wdata);
			cpu_read(addr, rdata);
			compare($sformatf("ram_q@%h", addr), 32'(wdata), 32'(rdata));
		end
	endtask

	task automatic program_area_erase();
		logic [ADDR_WIDTH-1:0] addrs [0:N_ACCESS-1];
		byte_t                 rdata;
		int                    i;
		int                    n;
		int                    reset_drops;
		for (i = 0; i < N_ACCESS; i++) begin
			if (i == 0)
				addrs[i] = ADDR_WIDTH'(PRG_BASE); // first swept byte
			else if (i == N_ACCESS - 1)
				addrs[i] = '1; // top byte
			else
				addrs[i] = ADDR_WIDTH'(PRG_BASE) | ADDR_WIDTH'($random(seed));
			cpu_write(addrs[i], byte_t'($random(seed)) | 8'h01); // never the fill value
		end
		@(negedge sys_clock);
		erase_trigger = 1'b1;
		@(negedge sys_clock);
		erase_trigger = 1'b0;
		compare("erase_busy", 1, 32'(boot_mem_top_inst.erase_busy));
		n           = 0;
		reset_drops = 0;
		while (boot_mem_top_inst.erase_busy && n < ERASE_LIMIT) begin
			if (!cpu_reset)
				reset_drops++; // cpu must stay parked
			@(negedge sys_clock);
			n++;
		end
		if (boot_mem_top_inst.erase_busy) begin
			$display("erase_busy still high after %0d cycles, erase never finished", n);
			errors++;
		end
		compare("cpu_reset low cycles during erase", 0, reset_drops);
		wait_cpu_run(); // checker reruns after the erase
		for (i = 0; i < N_ACCESS; i++) begin
			cpu_read(addrs[i], rdata);
			compare($sformatf("ram_q@%h", addrs[i]), 32'(FILL_BYTE), 32'(rdata));
		end
		for (i = 0; i < SIG_LEN; i++) begin
			cpu_read(ADDR_WIDTH'(i), rdata);
			compare($sformatf("ram_q@%h", i), 32'(ROM_SIG[i]), 32'(rdata));
		end
		compare("rom_ok", 1, 32'(rom_ok));
	endtask

	initial begin
		seed          = 55;
		errors        = 0;
		checks        = 0;
		RESET         = 1'b1;
		load_active   = 1'b0;
		load_wr       = 1'b0;
		load_addr     = '0;
		load_data     = '0;
		load_done     = 1'b0;
		erase_trigger = 1'b0;
		reset_key     = 1'b0;
		cpu_addr      = '0;
		cpu_wdata     = '0;
		cpu_wr        = 1'b0;
		reset_hold();
		good_rom_boot();
		bad_rom_boot();
		good_rom_boot(); // valid image again for the later tests
		random_ram_access();
		program_area_erase();
		$display("tb_boot_mem done, %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== sim.f ====
boot_mem_pkg.sv
boot_control.sv
ram_eraser.sv
rom_check.sv
mem_arbiter.sv
sys_ram.sv
boot_mem_top.sv
boot_mem_assertions.sv
tb_boot_mem.sv

// ==== Makefile ====
# Verilator build for the boot memory testbench

TOP := tb_boot_mem

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

obj_dir/V$(TOP): sim.f *.sv
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)

# pass or fail is taken from the log, not the exit code
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
